//--- vlog.f
src/uartPkg.sv
src/uartTx.sv
src/uartRx.sv
src/bistFsm.sv
src/uartApb.sv
src/uartTop.sv
verif/uartTb.sv

//--- run.sh
#!/bin/sh
# build the UART testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module uartTb -o uartSim \
	&& ./obj_dir/uartSim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

//--- verif/uartTb.sv
// directed testbench for the UART peripheral that drives APB and the serial line
// runs reset, transmit, receive, self-test and slave error tests in turn
`timescale 1ns/1ns

module uartTb
	import uartPkg::*;
();

	localparam int ClkPeriod  = 4;
	localparam int FrameNs    = FrameBits * ClksPerBit * ClkPeriod;
	// six tests of at most three frames each with four times margin
	localparam int WatchdogNs = 6 * 3 * FrameNs * 4;
	localparam int PollLimit  = 200;
	localparam int Seed       = 51271;

	logic                Clk;
	logic                Rst;
	logic                pSel;
	logic                pEnable;
	logic                pWrite;
	logic [AddrW-1:0]    pAddr;
	logic [DataBits-1:0] pWdata;
	logic [DataBits-1:0] pRdata;
	logic                pSlvErr;
	logic                uartRxd;
	logic                uartTxd;
	// board loopback flag that hands the receive line to the testbench when cleared
	logic                loopback;
	logic                rxdDrive;
	int                  errorCount;
	int                  testCount;
	int                  testErrStart;

	assign uartRxd = loopback ? uartTxd : rxdDrive;

	uartTop dut (.Clk, .Rst, .pSel, .pEnable, .pWrite, .pAddr, .pWdata, .pRdata,
		.pSlvErr, .uartRxd, .uartTxd);

	always #(ClkPeriod / 2) Clk = ~Clk;

	// stops a stuck run
	initial
	begin
		#(WatchdogNs);
		$display("watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

	task automatic expectValue(input logic [DataBits-1:0] actual,
		input logic [DataBits-1:0] expected, input string msg);
		assert (actual === expected)
		else
		begin
			$display("Error at %0t ns: %s, read %0h, expected %0h", $time, msg, actual,
				expected);
			errorCount++;
		end
	endtask

	task automatic expectBit(input logic actual, input logic expected, input string msg);
		assert (actual === expected)
		else
		begin
			$display("Error at %0t ns: %s, read %0b, expected %0b", $time, msg, actual,
				expected);
			errorCount++;
		end
	endtask

	// setup cycle, access cycle, sample mid access cycle, then idle
	task automatic apbAccess(input logic write, input logic [AddrW-1:0] addr,
		input logic [DataBits-1:0] wdata, output logic [DataBits-1:0] rdata,
		output logic err);
		@(posedge Clk);
		pSel    <= 1'b1;
		pEnable <= 1'b0;
		pWrite  <= write;
		pAddr   <= addr;
		pWdata  <= wdata;
		@(posedge Clk);
		pEnable <= 1'b1;
		// pRdata and pSlvErr are combinational in the access cycle
		@(negedge Clk);
		rdata = pRdata;
		err   = pSlvErr;
		@(posedge Clk);
		pSel    <= 1'b0;
		pEnable <= 1'b0;
		pWrite  <= 1'b0;
	endtask

	task automatic apbWrite(input logic [AddrW-1:0] addr, input logic [DataBits-1:0] data,
		output logic err);
		logic [DataBits-1:0] discard;
		apbAccess(1'b1, addr, data, discard, err);
	endtask

	task automatic apbRead(input logic [AddrW-1:0] addr, output logic [DataBits-1:0] data,
		output logic err);
		apbAccess(1'b0, addr, '0, data, err);
	endtask

	// poll the status register until one bit reaches the wanted level
	task automatic waitStatus(input int bitPos, input logic value);
		logic [DataBits-1:0] st;
		logic                err;
		int                  polls;
		polls = 0;
		apbRead(StatusReg, st, err);
		while ((st[bitPos] !== value) && (polls < PollLimit))
		begin
			apbRead(StatusReg, st, err);
			polls++;
		end
		assert (st[bitPos] === value)
		else
		begin
			$display("status bit %0d never reached %0b after %0d reads", bitPos, value, polls);
			errorCount++;
		end
	endtask

	// start bit, data LSB first, stop bit on the receive line
	task automatic sendFrame(input logic [DataBits-1:0] data);
		logic [FrameBits-1:0] bits;
		bits = {1'b1, data, 1'b0};
		@(posedge Clk);
		for (int i = 0; i < FrameBits; i++)
		begin
			rxdDrive <= bits[i];
			repeat (ClksPerBit) @(posedge Clk);
		end
	endtask

	// samples uartTxd near the middle of every bit
	task automatic captureFrame(output logic [DataBits-1:0] data, output logic framingOk);
		logic startBit;
		logic stopBit;
		while (uartTxd === 1'b1)
			@(negedge Clk);
		// half a bit into the start bit
		repeat (HalfBitClks) @(negedge Clk);
		startBit = uartTxd;
		for (int i = 0; i < DataBits; i++)
		begin
			repeat (ClksPerBit) @(negedge Clk);
			data[i] = uartTxd;
		end
		repeat (ClksPerBit) @(negedge Clk);
		stopBit   = uartTxd;
		framingOk = !startBit && stopBit;
	endtask

	// one report line per test
	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == testErrStart)
			$display("%s test: ok", name);
		else
			$display("%s test: %0d errors", name, errorCount - testErrStart);
	endtask

	task automatic testReset();
		logic [DataBits-1:0] st;
		logic                err;
		testErrStart = errorCount;
		apbRead(StatusReg, st, err);
		expectValue(st, 8'h00, "status after reset");
		expectBit(uartTxd, 1'b1, "uartTxd idle after reset");
		finishTest("reset");
	endtask

	task automatic testTransmit();
		logic [DataBits-1:0] txByte;
		logic [DataBits-1:0] seen;
		logic [DataBits-1:0] st;
		logic                ok;
		logic                err;
		testErrStart = errorCount;
		loopback <= 1'b0;
		rxdDrive <= 1'b1;
		txByte = 8'($urandom());
		apbWrite(TxDataReg, txByte, err);
		expectBit(err, 1'b0, "slave error on idle transmit write");
		fork
			captureFrame(seen, ok);
			// busy check a few bits into the frame
			begin
				repeat (3 * ClksPerBit) @(posedge Clk);
				apbRead(StatusReg, st, err);
				expectBit(st[TxBusyBit], 1'b1, "txBusy during frame");
			end
		join
		expectBit(ok, 1'b1, "start or stop bit on uartTxd");
		expectValue(seen, txByte, "byte on uartTxd");
		// frame lasts FrameBits bit times, so busy is gone by now
		repeat (ClksPerBit) @(posedge Clk);
		apbRead(StatusReg, st, err);
		expectBit(st[TxBusyBit], 1'b0, "txBusy after frame");
		finishTest("transmit");
	endtask

	task automatic testReceive();
		logic [DataBits-1:0] rxByte;
		logic [DataBits-1:0] data;
		logic [DataBits-1:0] st;
		logic                err;
		testErrStart = errorCount;
		loopback <= 1'b0;
		rxByte = 8'($urandom());
		sendFrame(rxByte);
		waitStatus(RxValidBit, 1'b1);
		apbRead(RxDataReg, data, err);
		expectValue(data, rxByte, "received byte");
		// reading the hold register consumes the byte
		apbRead(StatusReg, st, err);
		expectBit(st[RxValidBit], 1'b0, "rxValid after read");
		finishTest("receive");
	endtask

	task automatic testBistPass();
		logic [DataBits-1:0] seen;
		logic [DataBits-1:0] st;
		logic                ok;
		logic                err;
		testErrStart = errorCount;
		loopback <= 1'b1;
		fork
			captureFrame(seen, ok);
			begin
				apbWrite(CtrlReg, 8'h01, err);
				waitStatus(BistBusyBit, 1'b0);
			end
		join
		apbRead(StatusReg, st, err);
		expectBit(st[BistErrBit], 1'b0, "bistError after looped run");
		expectBit(st[RxValidBit], 1'b0, "rxValid during self-test");
		expectBit(ok, 1'b1, "framing of self-test frame");
		expectValue(seen, BistPattern, "self-test byte on uartTxd");
		finishTest("bist pass");
	endtask

	task automatic testBistFail();
		logic [DataBits-1:0] st;
		logic                err;
		testErrStart = errorCount;
		loopback <= 1'b0;
		rxdDrive <= 1'b1;
		apbWrite(CtrlReg, 8'h01, err);
		// wrong byte injected while the pattern goes nowhere
		sendFrame(8'h55);
		waitStatus(BistBusyBit, 1'b0);
		apbRead(StatusReg, st, err);
		expectBit(st[BistErrBit], 1'b1, "bistError after wrong byte");
		// close the loop once the lost pattern frame is out
		waitStatus(TxBusyBit, 1'b0);
		loopback <= 1'b1;
		apbWrite(CtrlReg, 8'h01, err);
		waitStatus(BistBusyBit, 1'b0);
		apbRead(StatusReg, st, err);
		expectBit(st[BistErrBit], 1'b0, "bistError after rerun");
		finishTest("bist fail");
	endtask

	task automatic testSlaveErrors();
		logic [DataBits-1:0] first;
		logic [DataBits-1:0] seen;
		logic [DataBits-1:0] data;
		logic                ok;
		logic                err;
		logic                busyErr;
		testErrStart = errorCount;
		loopback <= 1'b0;
		rxdDrive <= 1'b1;
		apbRead(4'd2, data, err);
		expectBit(err, 1'b1, "slave error on unmapped offset");
		first = 8'($urandom());
		apbWrite(TxDataReg, first, err);
		expectBit(err, 1'b0, "slave error on first transmit write");
		// second write lands while the first frame is on the line
		fork
			captureFrame(seen, ok);
			begin
				apbWrite(TxDataReg, ~first, busyErr);
				expectBit(busyErr, 1'b1, "slave error on write while busy");
			end
		join
		expectBit(ok, 1'b1, "framing of ongoing frame");
		expectValue(seen, first, "ongoing frame byte");
		waitStatus(TxBusyBit, 1'b0);
		finishTest("slave errors");
	endtask

	initial
	begin
		Clk        = 1'b0;
		Rst        = 1'b1;
		pSel       = 1'b0;
		pEnable    = 1'b0;
		pWrite     = 1'b0;
		pAddr      = '0;
		pWdata     = '0;
		rxdDrive   = 1'b1;
		loopback   = 1'b0;
		errorCount = 0;
		testCount  = 0;
		void'($urandom(Seed));
		repeat (3) @(posedge Clk);
		Rst <= 1'b0;
		@(posedge Clk);
		testReset();
		testTransmit();
		testReceive();
		testBistPass();
		testBistFail();
		testSlaveErrors();
		$display("%0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- src/uartTop.sv
// top level of the UART peripheral with APB access and loopback self-test
// uartTxd and uartRxd are looped on the board for the self-test
`timescale 1ns/1ns

module uartTop
	import uartPkg::*;
(
	input  logic                Clk,
	input  logic                Rst,
	input  logic                pSel,
	input  logic                pEnable,
	input  logic                pWrite,
	input  logic [AddrW-1:0]    pAddr,
	input  logic [DataBits-1:0] pWdata,
	output logic [DataBits-1:0] pRdata,
	output logic                pSlvErr,
	input  logic                uartRxd,
	output logic                uartTxd
);

	logic                txStart;
	logic [DataBits-1:0] txData;
	logic                txBusy;
	logic [DataBits-1:0] rxData;
	logic                rxDone;
	logic                hostTxStart;
	logic [DataBits-1:0] hostTxData;
	logic                bistStart;
	logic                bistMode;
	logic                bistTxStart;
	logic [DataBits-1:0] bistTxData;
	logic                bistBusy;
	logic                bistError;

	// in BIST mode only the controller drives the transmitter
	assign txStart = bistMode ? bistTxStart : hostTxStart;
	assign txData  = bistMode ? bistTxData : hostTxData;

	uartApb apb (.Clk, .Rst, .pSel, .pEnable, .pWrite, .pAddr, .pWdata, .pRdata,
		.pSlvErr, .txBusy, .rxData, .rxDone, .bistMode, .bistBusy, .bistError,
		.hostTxStart, .hostTxData, .bistStart);

	uartTx tx (.Clk, .Rst, .txStart, .txData, .txBusy, .uartTxd);

	uartRx rx (.Clk, .Rst, .uartRxd, .rxData, .rxDone);

	bistFsm bist (.Clk, .Rst, .bistStart, .txBusy, .rxDone, .rxData, .bistMode,
		.bistTxStart, .bistTxData, .bistBusy, .bistError);

endmodule

//--- src/uartApb.sv
// APB slave register block for the UART, all accesses complete with zero wait
// holds control, transmit, receive-hold and status registers
`timescale 1ns/1ns

module uartApb
	import uartPkg::*;
(
	input  logic                Clk,
	input  logic                Rst,
	input  logic                pSel,
	input  logic                pEnable,
	input  logic                pWrite,
	input  logic [AddrW-1:0]    pAddr,
	input  logic [DataBits-1:0] pWdata,
	output logic [DataBits-1:0] pRdata,
	output logic                pSlvErr,
	input  logic                txBusy,
	input  logic [DataBits-1:0] rxData,
	input  logic                rxDone,
	input  logic                bistMode,
	input  logic                bistBusy,
	input  logic                bistError,
	output logic                hostTxStart,
	output logic [DataBits-1:0] hostTxData,
	output logic                bistStart
);

	RegAddr              addr;
	logic                access;
	logic                wrAccess;
	logic                rdAccess;
	logic                mapped;
	logic                txWrite;
	logic                txReject;
	logic                rxValid;
	logic [DataBits-1:0] rxHold;
	logic [DataBits-1:0] status;
	logic [DataBits-1:0] rdMux;

	assign addr     = RegAddr'(pAddr);
	// transfer completes in the access phase
	assign access   = pSel && pEnable;
	assign wrAccess = access && pWrite;
	assign rdAccess = access && !pWrite;

	// host cannot start a frame during a frame or during self-test
	assign txWrite  = wrAccess && (addr == TxDataReg);
	assign txReject = txWrite && (txBusy || bistMode);

	always_comb
	begin
		status              = '0;
		status[TxBusyBit]   = txBusy;
		status[RxValidBit]  = rxValid;
		status[BistBusyBit] = bistBusy;
		status[BistErrBit]  = bistError;
		status[BistModeBit] = bistMode;
	end

	// address decode and read mux
	always_comb
	begin
		mapped = 1'b1;
		rdMux  = '0;
		case (addr)
			CtrlReg:   rdMux[0] = bistBusy;
			TxDataReg: rdMux    = hostTxData;
			RxDataReg: rdMux    = rxHold;
			StatusReg: rdMux    = status;
			default:   mapped   = 1'b0;
		endcase
	end

	assign pRdata  = rdAccess ? rdMux : '0;
	assign pSlvErr = (access && !mapped) || txReject;

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			hostTxStart <= 1'b0;
			hostTxData  <= '0;
			bistStart   <= 1'b0;
			rxValid     <= 1'b0;
			rxHold      <= '0;
		end
		else
		begin
			hostTxStart <= txWrite && !txReject;
			if (txWrite && !txReject)
				hostTxData <= pWdata;
			// a second start during a run is dropped
			bistStart <= wrAccess && (addr == CtrlReg) && pWdata[0] && !bistBusy;
			// in self-test the byte belongs to the BIST controller
			if (rxDone && !bistMode)
			begin
				rxValid <= 1'b1;
				rxHold  <= rxData;
			end
			else if (rdAccess && (addr == RxDataReg))
				rxValid <= 1'b0;
		end
	end

endmodule

//--- src/bistFsm.sv
// loopback self-test controller, sends BistPattern and compares what comes back
// bistError is sticky and clears only when the next run starts
`timescale 1ns/1ns

module bistFsm
	import uartPkg::*;
(
	input  logic                Clk,
	input  logic                Rst,
	input  logic                bistStart,
	input  logic                txBusy,
	input  logic                rxDone,
	input  logic [DataBits-1:0] rxData,
	output logic                bistMode,
	output logic                bistTxStart,
	output logic [DataBits-1:0] bistTxData,
	output logic                bistBusy,
	output logic                bistError
);

	BistState state;
	BistState nextState;
	// pattern already launched in this Loop visit
	logic     txSent;

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
			state <= Ready;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			Ready:
				if (bistStart)
					nextState = Active;
			// let any host frame finish first
			Active:
				if (!txBusy)
					nextState = Loop;
			// wait for the looped byte, however long it takes
			Loop:
				if (rxDone)
					nextState = Done;
			Done:
				nextState = Ready;
			default:
				nextState = Ready;
		endcase
	end

	// one transmit pulse on the first Loop cycle
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
			txSent <= 1'b0;
		else
			txSent <= (state == Loop);
	end

	// result latched in Done, cleared by a new start
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
			bistError <= 1'b0;
		else if ((state == Ready) && bistStart)
			bistError <= 1'b0;
		else if (state == Done)
			bistError <= (rxData != BistPattern);
	end

	// outputs follow the state
	assign bistMode    = (state == Active) || (state == Loop);
	assign bistBusy    = (state == Active) || (state == Loop);
	assign bistTxStart = (state == Loop) && !txSent;
	assign bistTxData  = (state == Loop) ? BistPattern : '0;

	activeFromReady: assert property (@(posedge Clk) disable iff (Rst)
		$rose(state == Active) |-> ($past(state) == Ready))
		else $error("Active entered from a state other than Ready");

	stateOneHot: assert property (@(posedge Clk) disable iff (Rst)
		$onehot(state))
		else $error("BIST state lost its one-hot encoding");

endmodule

//--- src/uartRx.sv
// UART receiver, samples each bit at its middle and checks the stop bit
// rxDone pulses for one cycle with the byte on rxData, bad frames are dropped
`timescale 1ns/1ns

module uartRx
	import uartPkg::*;
(
	input  logic                Clk,
	input  logic                Rst,
	input  logic                uartRxd,
	output logic [DataBits-1:0] rxData,
	output logic                rxDone
);

	// two sync flops plus one more for edge detection
	logic [2:0]          rxSync;
	logic                rxBit;
	logic                fallEdge;
	logic                rxActive;
	logic [BaudCntW-1:0] baudCnt;
	logic [BaudCntW-1:0] baudTarget;
	logic [BitCntW-1:0]  bitCnt;
	logic                sampleNow;
	logic                stopOk;
	logic                dataSample;
	logic [DataBits-1:0] shiftReg;

	assign rxBit    = rxSync[1];
	assign fallEdge = rxSync[2] && !rxSync[1];

	// half a bit to reach the middle of the start bit, full bits after that
	assign baudTarget = (bitCnt == '0) ? BaudCntW'(HalfBitClks - 1) :
		BaudCntW'(ClksPerBit - 1);
	assign sampleNow  = rxActive && (baudCnt == baudTarget);
	assign stopOk     = sampleNow && (bitCnt == BitCntW'(FrameBits - 1)) && rxBit;
	assign dataSample = sampleNow && (bitCnt != '0) &&
		(bitCnt != BitCntW'(FrameBits - 1));

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			rxSync   <= '1;
			rxActive <= 1'b0;
			baudCnt  <= '0;
			bitCnt   <= '0;
			rxDone   <= 1'b0;
		end
		else
		begin
			rxSync <= {rxSync[1:0], uartRxd};
			rxDone <= stopOk;
			if (!rxActive)
			begin
				baudCnt <= '0;
				bitCnt  <= '0;
				if (fallEdge)
					rxActive <= 1'b1;
			end
			else if (sampleNow)
			begin
				baudCnt <= '0;
				bitCnt  <= bitCnt + 1'b1;
				// glitch on the start bit or end of frame
				if ((bitCnt == '0) && rxBit)
					rxActive <= 1'b0;
				else if (bitCnt == BitCntW'(FrameBits - 1))
					rxActive <= 1'b0;
			end
			else
				baudCnt <= baudCnt + 1'b1;
		end
	end

	// data arrives LSB first, so shift in from the top
	always_ff @(posedge Clk)
	begin
		if (dataSample)
			shiftReg <= {rxBit, shiftReg[DataBits-1:1]};
		if (stopOk)
			rxData <= shiftReg;
	end

	// downstream logic counts each byte once
	rxDonePulse: assert property (@(posedge Clk) disable iff (Rst)
		rxDone |=> !rxDone)
		else $error("rxDone held longer than one cycle");

endmodule

//--- src/uartTx.sv
// UART transmitter, sends one start bit, the data LSB first and one stop bit
// a single-cycle txStart launches a frame, txBusy covers the whole frame
`timescale 1ns/1ns

module uartTx
	import uartPkg::*;
(
	input  logic                Clk,
	input  logic                Rst,
	input  logic                txStart,
	input  logic [DataBits-1:0] txData,
	output logic                txBusy,
	output logic                uartTxd
);

	// stop bit sits above the data so a right shift walks the frame
	logic [DataBits:0]   shiftReg;
	logic [BaudCntW-1:0] baudCnt;
	logic [BitCntW-1:0]  bitCnt;
	logic                bitEnd;

	// last clock of the current bit period
	assign bitEnd = (baudCnt == BaudCntW'(ClksPerBit - 1));

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			txBusy  <= 1'b0;
			uartTxd <= 1'b1;
			baudCnt <= '0;
			bitCnt  <= '0;
		end
		else if (!txBusy)
		begin
			baudCnt <= '0;
			bitCnt  <= '0;
			// start bit goes out in the cycle after the start pulse
			if (txStart)
			begin
				txBusy  <= 1'b1;
				uartTxd <= 1'b0;
			end
		end
		else if (bitEnd)
		begin
			baudCnt <= '0;
			if (bitCnt == BitCntW'(FrameBits - 1))
			begin
				// end of stop bit, line is already high
				txBusy <= 1'b0;
			end
			else
			begin
				uartTxd <= shiftReg[0];
				bitCnt  <= bitCnt + 1'b1;
			end
		end
		else
			baudCnt <= baudCnt + 1'b1;
	end

	// payload shifter, loaded on start and advanced once per bit
	always_ff @(posedge Clk)
	begin
		if (!txBusy && txStart)
			shiftReg <= {1'b1, txData};
		else if (txBusy && bitEnd)
			shiftReg <= {1'b1, shiftReg[DataBits:1]};
	end

	// both start sources must wait for the end of the current frame
	txStartWhileBusy: assert property (@(posedge Clk) disable iff (Rst)
		txBusy |-> !txStart)
		else $error("transmit start while a frame is in progress");

endmodule

//--- src/uartPkg.sv
// shared constants and enums for the UART peripheral with loopback self-test
// modules pull these in with a wildcard import in their header

package uartPkg;

	// serial frame layout: one start bit, the data bits, one stop bit
	localparam int DataBits  = 8;
	localparam int FrameBits = DataBits + 2;

	// bit timing, kept short so simulation stays fast
	localparam int ClksPerBit  = 8;
	localparam int HalfBitClks = ClksPerBit / 2;
	localparam int BaudCntW    = $clog2(ClksPerBit);
	localparam int BitCntW     = $clog2(FrameBits);

	// byte sent and expected back during the self-test
	localparam logic [DataBits-1:0] BistPattern = 8'hAA;

	// APB address width
	localparam int AddrW = 4;

	// register offsets on the APB port
	typedef enum logic [AddrW-1:0] {
		CtrlReg   = 4'd0,
		TxDataReg = 4'd4,
		RxDataReg = 4'd8,
		StatusReg = 4'd12
	} RegAddr;

	// status register bit positions
	localparam int TxBusyBit   = 0;
	localparam int RxValidBit  = 1;
	localparam int BistBusyBit = 2;
	localparam int BistErrBit  = 3;
	localparam int BistModeBit = 4;

	// self-test controller states, one-hot
	typedef enum logic [3:0] {
		Ready  = 4'b0001,
		Active = 4'b0010,
		Loop   = 4'b0100,
		Done   = 4'b1000
	} BistState;

endpackage
